// ==== hdl/wb_defines.svh ====
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// result slots carried by one micro-op
`define WB_SLOTS 4

`define WB_DATA_W 64  // slot data
`define WB_ADDR_W 32  // address and eip
`define WB_REG_W 3    // gpr or segment index

`define WB_STQ_DEPTH 4  // store queue entries
`define WB_RDQ_DEPTH 2  // redirect queue entries

`endif

// ==== hdl/wb_pkg.sv ====
`include "wb_defines.svh"

package wb_pkg;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] data;
        logic [`WB_ADDR_W-1:0] dest;  // reg index in low bits, or mem address
        logic                  is_reg;
        logic                  is_seg;
        logic                  is_mem;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [`WB_SLOTS-1:0] slot;
        logic [1:0]               size;
        logic [`WB_ADDR_W-1:0]    eip;        // fall-through eip
        logic                     far_xfer;   // loads cs:eip
        logic                     br_valid;
        logic                     br_taken;
        logic                     br_correct;
        logic [`WB_ADDR_W-1:0]    br_fip;     // branch target
        logic [`WB_ADDR_W-5:0]    br_fip_p1;  // next 16B line of target
        logic [15:0]              cs;
        logic                     ie;
        logic [2:0]               ie_type;
    } wb_uop_t;

    typedef struct packed {
        logic [`WB_SLOTS-1:0]                 reg_ld;
        logic [`WB_SLOTS-1:0]                 seg_ld;
        logic [`WB_SLOTS-1:0][`WB_REG_W-1:0]  reg_addr;
        logic [`WB_SLOTS-1:0][`WB_REG_W-1:0]  seg_addr;
        logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0] res;
        logic [1:0]                           size;
    } wb_regwr_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] data;
        logic [1:0]            size;
    } wb_store_t;

    // restart request sent to fetch
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] new_eip;
        logic [`WB_ADDR_W-1:0] fip_e;
        logic [`WB_ADDR_W-1:0] fip_o;
        logic [15:0]           cs;
        logic                  resteer;
        logic                  ie_val;
        logic [3:0]            ie_type;  // bit 3 is the external interrupt
    } wb_redirect_t;

endpackage

// ==== hdl/wb_queue.sv ====
module wb_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t dout
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(DEPTH));  // a pop in the same cycle frees no slot
    assign out_valid = (count != '0);
    assign dout      = mem[rd_ptr];  // fall-through head
    assign do_push   = push & ~full;
    assign do_pop    = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/wb_redirect_unit.sv ====
`include "wb_defines.svh"

module wb_redirect_unit (
    input  wb_pkg::wb_uop_t      uop,
    input  logic                 interrupt_in,
    output wb_pkg::wb_redirect_t redir,
    output logic                 need_redir
);

    logic [`WB_ADDR_W-1:0] target;
    logic [`WB_ADDR_W-1:0] line_cur;
    logic [`WB_ADDR_W-1:0] line_next;
    logic                  resteer;
    logic                  ie_val;

    // far transfers take eip from slot 0
    assign target = uop.far_xfer ? uop.slot[0].data[`WB_ADDR_W-1:0] : uop.br_fip;

    assign line_cur  = {target[`WB_ADDR_W-1:4], 4'd0};
    assign line_next = {uop.br_fip_p1, 4'd0};

    assign resteer = uop.far_xfer | (uop.br_valid & ~uop.br_correct);
    assign ie_val  = uop.ie | interrupt_in;

    always_comb begin
        if (uop.br_taken || uop.far_xfer) begin
            redir.new_eip = target;
        end else begin
            redir.new_eip = uop.eip;
        end

        // bit 4 picks which bank holds the target line
        if (!target[4]) begin
            redir.fip_e = line_cur;
            redir.fip_o = line_next;
        end else begin
            redir.fip_e = line_next;
            redir.fip_o = line_cur;
        end

        redir.cs      = uop.cs;
        redir.resteer = resteer;
        redir.ie_val  = ie_val;
        redir.ie_type = {interrupt_in, uop.ie_type};
    end

    assign need_redir = resteer | ie_val;

endmodule

// ==== hdl/wb_result_router.sv ====
`include "wb_defines.svh"

module wb_result_router (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              accept,
    input  wb_pkg::wb_uop_t   uop,
    output wb_pkg::wb_regwr_t regwr,
    output logic              has_store,
    output wb_pkg::wb_store_t store
);

    logic [`WB_SLOTS-1:0] reg_hit;
    logic [`WB_SLOTS-1:0] seg_hit;
    logic [`WB_SLOTS-1:0] mem_hit;

    logic [`WB_SLOTS-1:0] reg_ld_q;
    logic [`WB_SLOTS-1:0] seg_ld_q;

    logic [`WB_SLOTS-1:0][`WB_REG_W-1:0]  addr_d;
    logic [`WB_SLOTS-1:0][`WB_REG_W-1:0]  addr_q;
    logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0] res_d;
    logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0] res_q;
    logic [1:0]                           size_q;

    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            reg_hit[i] = uop.slot[i].is_reg;
            seg_hit[i] = uop.slot[i].is_seg;
            mem_hit[i] = uop.slot[i].is_mem;
            addr_d[i]  = uop.slot[i].dest[`WB_REG_W-1:0];
            res_d[i]   = uop.slot[i].data;
        end
        if (uop.far_xfer) begin
            res_d[0] = {{(`WB_DATA_W-16){1'b0}}, uop.slot[0].data[47:32]};  // cs selector
        end
    end

    // write strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_ld_q <= '0;
            seg_ld_q <= '0;
        end else begin
            reg_ld_q <= accept ? reg_hit : '0;
            seg_ld_q <= accept ? seg_hit : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr_d;
            res_q  <= res_d;
            size_q <= uop.size;
        end
    end

    always_comb begin
        regwr.reg_ld   = reg_ld_q;
        regwr.seg_ld   = seg_ld_q;
        regwr.reg_addr = addr_q;  // same index field feeds both files
        regwr.seg_addr = addr_q;
        regwr.res      = res_q;
        regwr.size     = size_q;
    end

    assign has_store = |mem_hit;

    // walk downward so the lowest memory slot wins
    always_comb begin
        store = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                store.addr = uop.slot[i].dest;
                store.data = uop.slot[i].data;
            end
        end
        store.size = uop.far_xfer ? 2'd3 : uop.size;  // far push is full width
    end

endmodule

// ==== hdl/writeback_top.sv ====
`include "wb_defines.svh"

module writeback_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  wb_pkg::wb_uop_t      uop_in,
    input  logic                 interrupt_in,
    output wb_pkg::wb_regwr_t    regwr,
    output logic                 stall,
    output logic                 store_valid,
    output wb_pkg::wb_store_t    store_out,
    input  logic                 store_ready,
    output logic                 redir_valid,
    output wb_pkg::wb_redirect_t redir_out,
    input  logic                 redir_ready
);

    logic                 accept;
    logic                 has_store;
    logic                 need_redir;
    logic                 stq_full;
    logic                 rdq_full;
    wb_pkg::wb_store_t    store_d;
    wb_pkg::wb_redirect_t redir_d;

    // hold the uop only when a queue it needs is full
    assign stall  = valid_in & ((has_store & stq_full) | (need_redir & rdq_full));
    assign accept = valid_in & ~stall;

    wb_result_router i_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .uop       (uop_in),
        .regwr     (regwr),
        .has_store (has_store),
        .store     (store_d)
    );

    wb_redirect_unit i_redirect (
        .uop          (uop_in),
        .interrupt_in (interrupt_in),
        .redir        (redir_d),
        .need_redir   (need_redir)
    );

    // stores toward memory
    wb_queue #(
        .payload_t (wb_pkg::wb_store_t),
        .DEPTH     (`WB_STQ_DEPTH)
    ) i_store_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (accept & has_store),
        .din       (store_d),
        .full      (stq_full),
        .out_valid (store_valid),
        .out_ready (store_ready),
        .dout      (store_out)
    );

    // restart records toward fetch
    wb_queue #(
        .payload_t (wb_pkg::wb_redirect_t),
        .DEPTH     (`WB_RDQ_DEPTH)
    ) i_redir_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (accept & need_redir),
        .din       (redir_d),
        .full      (rdq_full),
        .out_valid (redir_valid),
        .out_ready (redir_ready),
        .dout      (redir_out)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the writeback testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sim_writeback
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f writeback_subsys.f --top-module tb_writeback \
    -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== testbench/tb_writeback.sv ====
`include "wb_defines.svh"

module tb_writeback;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int RUN_CYCLES    = 400;
    localparam int DRAIN_CYCLES  = 200;
    localparam int STALL_STRETCH = 20;  // ready held low this long
    localparam int WATCHDOG_NS   = (RESET_CYCLES + RUN_CYCLES + DRAIN_CYCLES) * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 valid_in;
    wb_pkg::wb_uop_t      uop_in;
    logic                 interrupt_in;
    wb_pkg::wb_regwr_t    regwr;
    logic                 stall;
    logic                 store_valid;
    wb_pkg::wb_store_t    store_out;
    logic                 store_ready;
    logic                 redir_valid;
    wb_pkg::wb_redirect_t redir_out;
    logic                 redir_ready;
    logic                 end_of_test;
    logic                 report_done;
    int                   value_errors;
    int                   other_errors;

    int   seed;
    logic held;      // current uop was stalled on the last edge
    int   stq_hold;
    int   rdq_hold;

    always #(CLK_PERIOD / 2) clk = ~clk;

    writeback_top i_dut (.*);

    wb_checker i_checker (.*);

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic drive_readies();
        if (stq_hold > 0) begin
            store_ready = 1'b0;
            stq_hold--;
        end else if (rand_below(60) == 0) begin
            store_ready = 1'b0;
            stq_hold    = STALL_STRETCH - 1;
        end else begin
            store_ready = rand_below(4) != 0;
        end
        if (rdq_hold > 0) begin
            redir_ready = 1'b0;
            rdq_hold--;
        end else if (rand_below(60) == 0) begin
            redir_ready = 1'b0;
            rdq_hold    = STALL_STRETCH - 1;
        end else begin
            redir_ready = rand_below(4) != 0;
        end
    endtask

    task automatic drive_uop();
        wb_pkg::wb_uop_t u;
        u = '0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            u.slot[i].data   = {$random(seed), $random(seed)};
            u.slot[i].dest   = $random(seed);
            u.slot[i].is_reg = rand_below(2) != 0;
            u.slot[i].is_seg = rand_below(4) == 0;
            u.slot[i].is_mem = rand_below(4) == 0;
        end
        u.size       = 2'(rand_below(4));
        u.eip        = $random(seed);
        u.far_xfer   = rand_below(8) == 0;
        u.br_valid   = rand_below(2) != 0;
        u.br_taken   = rand_below(2) != 0;
        u.br_correct = rand_below(4) != 0;
        u.br_fip     = $random(seed);
        u.br_fip_p1  = u.br_fip[`WB_ADDR_W-1:4] + 28'd1;  // line after the target
        u.cs         = 16'($random(seed));
        u.ie         = rand_below(8) == 0;
        u.ie_type    = 3'(rand_below(8));
        uop_in       = u;
        valid_in     = rand_below(10) < 7;
        interrupt_in = rand_below(16) == 0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed         = 24;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        uop_in       = '0;
        interrupt_in = 1'b0;
        store_ready  = 1'b0;
        redir_ready  = 1'b0;
        end_of_test  = 1'b0;
        held         = 1'b0;
        stq_hold     = 0;
        rdq_hold     = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        repeat (RUN_CYCLES) begin
            drive_readies();
            if (!held) drive_uop();  // a stalled uop stays on the bus
            @(posedge clk);
            held = valid_in && stall;
            @(negedge clk);
        end

        // drain with both consumers ready
        store_ready = 1'b1;
        redir_ready = 1'b1;
        while (held) begin
            @(posedge clk);
            held = valid_in && stall;
            @(negedge clk);
        end
        valid_in = 1'b0;
        while (store_valid || redir_valid) @(negedge clk);
        end_of_test = 1'b1;
        wait (report_done);
        @(negedge clk);

        $display("error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/wb_checker.sv ====
`include "wb_defines.svh"

module wb_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  wb_pkg::wb_uop_t      uop_in,
    input  logic                 interrupt_in,
    input  wb_pkg::wb_regwr_t    regwr,
    input  logic                 stall,
    input  logic                 store_valid,
    input  wb_pkg::wb_store_t    store_out,
    input  logic                 store_ready,
    input  logic                 redir_valid,
    input  wb_pkg::wb_redirect_t redir_out,
    input  logic                 redir_ready,
    input  logic                 end_of_test,
    output int                   value_errors,
    output int                   other_errors,
    output logic                 report_done
);
    timeunit 1ns;
    timeprecision 1ps;

    wb_pkg::wb_store_t    stq_sb[$];  // stores expected at the memory port
    wb_pkg::wb_redirect_t rdq_sb[$];
    wb_pkg::wb_regwr_t    exp_regwr;
    wb_pkg::wb_redirect_t exp_redir;
    logic                 exp_acc;    // acceptance on the previous edge
    logic                 exp_stall;
    logic                 uop_has_store;
    logic                 uop_needs_redir;

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        value_errors++;
        $display("[ERROR] %0t ns %s exp=%0h act=%0h", $time, name, exp, act);
    endtask

    function automatic wb_pkg::wb_regwr_t model_regwr(input wb_pkg::wb_uop_t u);
        wb_pkg::wb_regwr_t w;
        w = '0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            w.reg_ld[i]   = u.slot[i].is_reg;
            w.seg_ld[i]   = u.slot[i].is_seg;
            w.reg_addr[i] = u.slot[i].dest[`WB_REG_W-1:0];
            w.seg_addr[i] = u.slot[i].dest[`WB_REG_W-1:0];
            w.res[i]      = u.slot[i].data;
        end
        if (u.far_xfer) begin
            w.res[0] = {48'h0, u.slot[0].data[47:32]};  // selector only
        end
        w.size = u.size;
        return w;
    endfunction

    function automatic wb_pkg::wb_store_t model_store(input wb_pkg::wb_uop_t u);
        wb_pkg::wb_store_t s;
        logic              found;
        s     = '0;
        found = 1'b0;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            if (!found && u.slot[i].is_mem) begin
                s.addr = u.slot[i].dest;
                s.data = u.slot[i].data;
                found  = 1'b1;
            end
        end
        s.size = u.far_xfer ? 2'd3 : u.size;
        return s;
    endfunction

    function automatic wb_pkg::wb_redirect_t model_redirect(input wb_pkg::wb_uop_t u,
                                                            input logic intr);
        wb_pkg::wb_redirect_t  r;
        logic [`WB_ADDR_W-1:0] tgt;
        logic [`WB_ADDR_W-1:0] this_line;
        logic [`WB_ADDR_W-1:0] next_line;
        tgt       = u.far_xfer ? u.slot[0].data[`WB_ADDR_W-1:0] : u.br_fip;
        this_line = tgt & ~32'hF;
        next_line = {u.br_fip_p1, 4'h0};
        r.new_eip = (u.br_taken || u.far_xfer) ? tgt : u.eip;
        r.fip_e   = tgt[4] ? next_line : this_line;  // odd line goes to the odd pointer
        r.fip_o   = tgt[4] ? this_line : next_line;
        r.cs      = u.cs;
        r.resteer = u.far_xfer || (u.br_valid && !u.br_correct);
        r.ie_val  = u.ie || intr;
        r.ie_type = {intr, u.ie_type};
        return r;
    endfunction

    task automatic check_regwr();
        if (regwr.reg_ld !== exp_regwr.reg_ld)
            report_mismatch("regwr.reg_ld", 128'(exp_regwr.reg_ld), 128'(regwr.reg_ld));
        if (regwr.seg_ld !== exp_regwr.seg_ld)
            report_mismatch("regwr.seg_ld", 128'(exp_regwr.seg_ld), 128'(regwr.seg_ld));
        if (!exp_acc) return;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            if (exp_regwr.reg_ld[i] && regwr.reg_addr[i] !== exp_regwr.reg_addr[i])
                report_mismatch($sformatf("regwr.reg_addr[%0d]", i),
                                128'(exp_regwr.reg_addr[i]), 128'(regwr.reg_addr[i]));
            if (exp_regwr.seg_ld[i] && regwr.seg_addr[i] !== exp_regwr.seg_addr[i])
                report_mismatch($sformatf("regwr.seg_addr[%0d]", i),
                                128'(exp_regwr.seg_addr[i]), 128'(regwr.seg_addr[i]));
            if ((exp_regwr.reg_ld[i] || exp_regwr.seg_ld[i]) && regwr.res[i] !== exp_regwr.res[i])
                report_mismatch($sformatf("regwr.res[%0d]", i),
                                128'(exp_regwr.res[i]), 128'(regwr.res[i]));
        end
        if (regwr.size !== exp_regwr.size)
            report_mismatch("regwr.size", 128'(exp_regwr.size), 128'(regwr.size));
    endtask

    task automatic check_store_port();
        wb_pkg::wb_store_t exp;
        if (store_valid !== (stq_sb.size() != 0))
            report_mismatch("store_valid", 128'(stq_sb.size() != 0), 128'(store_valid));
        if (store_valid !== 1'b1 || store_ready !== 1'b1) return;
        if (stq_sb.size() == 0) begin
            other_errors++;
            $display("%0t ns a store left the queue while none was expected", $time);
            return;
        end
        exp = stq_sb.pop_front();
        if (store_out.addr !== exp.addr)
            report_mismatch("store_out.addr", 128'(exp.addr), 128'(store_out.addr));
        if (store_out.data !== exp.data)
            report_mismatch("store_out.data", 128'(exp.data), 128'(store_out.data));
        if (store_out.size !== exp.size)
            report_mismatch("store_out.size", 128'(exp.size), 128'(store_out.size));
    endtask

    task automatic check_redir_port();
        wb_pkg::wb_redirect_t exp;
        if (redir_valid !== (rdq_sb.size() != 0))
            report_mismatch("redir_valid", 128'(rdq_sb.size() != 0), 128'(redir_valid));
        if (redir_valid !== 1'b1 || redir_ready !== 1'b1) return;
        if (rdq_sb.size() == 0) begin
            other_errors++;
            $display("%0t ns a redirect left the queue while none was expected", $time);
            return;
        end
        exp = rdq_sb.pop_front();
        if (redir_out.new_eip !== exp.new_eip)
            report_mismatch("redir_out.new_eip", 128'(exp.new_eip), 128'(redir_out.new_eip));
        if (redir_out.fip_e !== exp.fip_e)
            report_mismatch("redir_out.fip_e", 128'(exp.fip_e), 128'(redir_out.fip_e));
        if (redir_out.fip_o !== exp.fip_o)
            report_mismatch("redir_out.fip_o", 128'(exp.fip_o), 128'(redir_out.fip_o));
        if (redir_out.cs !== exp.cs)
            report_mismatch("redir_out.cs", 128'(exp.cs), 128'(redir_out.cs));
        if (redir_out.resteer !== exp.resteer)
            report_mismatch("redir_out.resteer", 128'(exp.resteer), 128'(redir_out.resteer));
        if (redir_out.ie_val !== exp.ie_val)
            report_mismatch("redir_out.ie_val", 128'(exp.ie_val), 128'(redir_out.ie_val));
        if (redir_out.ie_type !== exp.ie_type)
            report_mismatch("redir_out.ie_type", 128'(exp.ie_type), 128'(redir_out.ie_type));
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_acc      = 1'b0;
            exp_regwr    = '0;
            value_errors = 0;
            other_errors = 0;
            report_done  = 1'b0;
            stq_sb.delete();
            rdq_sb.delete();
        end else begin
            check_regwr();
            exp_redir       = model_redirect(uop_in, interrupt_in);
            uop_has_store   = |{uop_in.slot[3].is_mem, uop_in.slot[2].is_mem,
                                uop_in.slot[1].is_mem, uop_in.slot[0].is_mem};
            uop_needs_redir = exp_redir.resteer || exp_redir.ie_val;
            // fill levels before this edge's pops
            exp_stall = valid_in &&
                        ((uop_has_store && stq_sb.size() == `WB_STQ_DEPTH) ||
                         (uop_needs_redir && rdq_sb.size() == `WB_RDQ_DEPTH));
            if (stall !== exp_stall)
                report_mismatch("stall", 128'(exp_stall), 128'(stall));
            check_store_port();
            check_redir_port();
            exp_acc = valid_in && !exp_stall;
            if (exp_acc) begin
                exp_regwr = model_regwr(uop_in);
                if (uop_has_store) stq_sb.push_back(model_store(uop_in));
                if (uop_needs_redir) rdq_sb.push_back(exp_redir);
            end else begin
                exp_regwr.reg_ld = '0;
                exp_regwr.seg_ld = '0;
            end
            if (end_of_test && !report_done) begin
                if (stq_sb.size() != 0) begin
                    other_errors++;
                    $display("%0d expected stores never left the store queue", stq_sb.size());
                end
                if (rdq_sb.size() != 0) begin
                    other_errors++;
                    $display("%0d expected redirects never left the redirect queue",
                             rdq_sb.size());
                end
                report_done = 1'b1;
            end
        end
    end

endmodule

// ==== writeback_subsys.f ====
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_result_router.sv
hdl/wb_redirect_unit.sv
hdl/wb_queue.sv
hdl/writeback_top.sv
testbench/wb_checker.sv
testbench/tb_writeback.sv
